//--- hw/dnc_config.svh
/*
  Build-time sizes for the DNC read-vector datapath.
  Included by the package, the RTL that sizes addresses and the testbench.
  Change the maximum matrix sizes here and keep DNC_ADDR_SIZE large enough
  for DNC_MAX_N * DNC_MAX_W and DNC_MAX_R * DNC_MAX_N.
*/

`ifndef DNC_CONFIG_SVH
`define DNC_CONFIG_SVH

// Memory word and read-vector element width
`define DNC_DATA_SIZE 16

// Read weighting element, unsigned
`define DNC_WEIGHT_SIZE 8

// Largest rows, word slots and read heads
`define DNC_MAX_N 8
`define DNC_MAX_W 8
`define DNC_MAX_R 4

// Flattened store address, 64 entries
`define DNC_ADDR_SIZE 6

`endif

//--- hw/dnc_pkg.sv
/*
  Shared types for the DNC read-vector subsystem.
  Widths come from the config header; modules import what they need.
*/

`default_nettype none

`include "dnc_config.svh"

package dnc_pkg;

  //////////////////////////////////////////////////
  // Size bookkeeping
  //////////////////////////////////////////////////

  // Largest of the three configured maxima
  localparam int MAX_NW   = (`DNC_MAX_N > `DNC_MAX_W) ? `DNC_MAX_N : `DNC_MAX_W;
  localparam int MAX_SIZE = (MAX_NW > `DNC_MAX_R) ? MAX_NW : `DNC_MAX_R;

  // Must hold the maximum itself, not just max-1
  localparam int COUNT_SIZE = $clog2(MAX_SIZE + 1);

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // Memory word, also a read-vector element
  typedef logic [`DNC_DATA_SIZE-1:0]   data_t;
  // Weighting element
  typedef logic [`DNC_WEIGHT_SIZE-1:0] weight_t;
  // Matrix size or row/column index
  typedef logic [COUNT_SIZE-1:0]       count_t;
  // Flattened store address
  typedef logic [`DNC_ADDR_SIZE-1:0]   addr_t;

endpackage

`default_nettype wire

//--- hw/dnc_matrix_store.sv
/*
  Matrix buffer for one operand of the read-vector product.
  One synchronous write port, one read port with a registered output.
  Read data shows up one cycle after the address.
  T selects the element type, so memory words and weights share this block.
*/

`default_nettype none

module dnc_matrix_store #(
  parameter type T     = logic,
  parameter int  DEPTH = 64
) (
  input  wire logic           CLK,

  // Write side, loader
  input  wire logic           wr_en,
  input  wire dnc_pkg::addr_t wr_addr,
  input  wire T               wr_data,

  // Read side, accumulator
  input  wire dnc_pkg::addr_t rd_addr,
  output T                    rd_data
);

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  // Only the low bits of the shared address reach the array
  localparam int INDEX_SIZE = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T mem [DEPTH];

  logic [INDEX_SIZE-1:0] wr_index;
  logic [INDEX_SIZE-1:0] rd_index;

  assign wr_index = wr_addr[INDEX_SIZE-1:0];
  assign rd_index = rd_addr[INDEX_SIZE-1:0];

  //////////////////////////////////////////////////
  // Ports
  //////////////////////////////////////////////////

  // Write port
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_index] <= wr_data;
    end
  end

  // Registered read, old data on a same-address write
  always_ff @(posedge CLK) begin
    rd_data <= mem[rd_index];
  end

endmodule

`default_nettype wire

//--- hw/dnc_read_loader.sv
/*
  Producer side of the read-vector block.
  Latches R, N and W at START, then turns the strobed M and w streams into
  store writes. The two streams are tracked independently and may interleave.
  load_done pulses one cycle after the last element of both streams is written.
*/

`default_nettype none

`include "dnc_config.svh"

module dnc_read_loader (
  input  wire logic            CLK,
  input  wire logic            RST,

  input  wire logic            START,
  input  wire dnc_pkg::count_t SIZE_R_IN,
  input  wire dnc_pkg::count_t SIZE_N_IN,
  input  wire dnc_pkg::count_t SIZE_W_IN,

  // M stream, row-major
  input  wire logic            M_IN_J_ENABLE,
  input  wire logic            M_IN_K_ENABLE,
  input  wire dnc_pkg::data_t  M_IN,

  // w stream, head-major
  input  wire logic            W_IN_I_ENABLE,
  input  wire logic            W_IN_J_ENABLE,
  input  wire dnc_pkg::weight_t W_IN,

  // Store writes
  output logic                 m_wr_en,
  output dnc_pkg::addr_t       m_wr_addr,
  output dnc_pkg::data_t       m_wr_data,
  output logic                 w_wr_en,
  output dnc_pkg::addr_t       w_wr_addr,
  output dnc_pkg::weight_t     w_wr_data,

  // To the accumulator
  output logic                 load_done,
  output dnc_pkg::count_t      r_size,
  output dnc_pkg::count_t      n_size,
  output dnc_pkg::count_t      w_size
);

  import dnc_pkg::*;

  //////////////////////////////////////////////////
  // Declarations
  //////////////////////////////////////////////////

  // Element counts reach N*W, one bit more than an address
  localparam int ELEM_SIZE = `DNC_ADDR_SIZE + 1;

  typedef enum logic {LOAD_IDLE, LOAD_BUSY} load_state_t;

  load_state_t          state;

  // Row/column trackers, row starts at all ones
  count_t               m_row, m_col, w_head, w_row;
  count_t               m_row_cur, m_col_cur, w_head_cur, w_row_cur;

  logic [ELEM_SIZE-1:0] m_count, w_count;
  logic [ELEM_SIZE-1:0] m_count_next, w_count_next;
  logic [ELEM_SIZE-1:0] m_total, w_total;
  logic                 m_full, w_full;

  //////////////////////////////////////////////////
  // Element position and store writes
  //////////////////////////////////////////////////

  // Row start rides with the first element of the row
  assign m_row_cur  = M_IN_J_ENABLE ? count_t'(m_row + 1'b1) : m_row;
  assign m_col_cur  = M_IN_J_ENABLE ? '0 : m_col;
  assign w_head_cur = W_IN_I_ENABLE ? count_t'(w_head + 1'b1) : w_head;
  assign w_row_cur  = W_IN_I_ENABLE ? '0 : w_row;

  // Nothing is written while idle
  assign m_wr_en   = (state == LOAD_BUSY) && M_IN_K_ENABLE;
  assign m_wr_addr = addr_t'(m_row_cur) * addr_t'(`DNC_MAX_W) + addr_t'(m_col_cur);
  assign m_wr_data = M_IN;

  assign w_wr_en   = (state == LOAD_BUSY) && W_IN_J_ENABLE;
  assign w_wr_addr = addr_t'(w_head_cur) * addr_t'(`DNC_MAX_N) + addr_t'(w_row_cur);
  assign w_wr_data = W_IN;

  // Completion, counting this cycle's write
  assign m_total      = ELEM_SIZE'(n_size) * ELEM_SIZE'(w_size);
  assign w_total      = ELEM_SIZE'(r_size) * ELEM_SIZE'(n_size);
  assign m_count_next = m_count + ELEM_SIZE'(m_wr_en);
  assign w_count_next = w_count + ELEM_SIZE'(w_wr_en);
  assign m_full       = (m_count_next == m_total);
  assign w_full       = (w_count_next == w_total);

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= LOAD_IDLE;
      load_done <= 1'b0;
      r_size    <= '0;
      n_size    <= '0;
      w_size    <= '0;
      m_row     <= '0;
      m_col     <= '0;
      w_head    <= '0;
      w_row     <= '0;
      m_count   <= '0;
      w_count   <= '0;
    end else begin
      load_done <= 1'b0;
      case (state)
        LOAD_IDLE: begin
          if (START) begin
            r_size  <= SIZE_R_IN;
            n_size  <= SIZE_N_IN;
            w_size  <= SIZE_W_IN;
            // First row strobe wraps these to zero
            m_row   <= '1;
            w_head  <= '1;
            m_col   <= '0;
            w_row   <= '0;
            m_count <= '0;
            w_count <= '0;
            state   <= LOAD_BUSY;
          end
        end
        LOAD_BUSY: begin
          if (M_IN_K_ENABLE) begin
            m_row <= m_row_cur;
            m_col <= count_t'(m_col_cur + 1'b1);
          end
          if (W_IN_J_ENABLE) begin
            w_head <= w_head_cur;
            w_row  <= count_t'(w_row_cur + 1'b1);
          end
          m_count <= m_count_next;
          w_count <= w_count_next;
          // Both matrices complete
          if (m_full && w_full) begin
            load_done <= 1'b1;
            state     <= LOAD_IDLE;
          end
        end
        default: state <= LOAD_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/dnc_read_accumulator.sv
/*
  Consumer side of the read-vector block.
  After load_done, walks i (outer), k and j (inner), reading M(j,k) and w(i,j)
  one pair of addresses per cycle, and accumulates over j.
  Each r(i,k) leaves on R_OUT with R_OUT_K_ENABLE; READY follows the last one.
  First result arrives N+2 cycles after load_done, then one every N cycles.
*/

`default_nettype none

`include "dnc_config.svh"

module dnc_read_accumulator (
  input  wire logic             CLK,
  input  wire logic             RST,

  // From the loader
  input  wire logic             load_done,
  input  wire dnc_pkg::count_t  r_size,
  input  wire dnc_pkg::count_t  n_size,
  input  wire dnc_pkg::count_t  w_size,

  // Store read ports
  output dnc_pkg::addr_t        m_rd_addr,
  output dnc_pkg::addr_t        w_rd_addr,
  input  wire dnc_pkg::data_t   m_rd_data,
  input  wire dnc_pkg::weight_t w_rd_data,

  // Result stream
  output dnc_pkg::data_t        R_OUT,
  output logic                  R_OUT_I_ENABLE,
  output logic                  R_OUT_K_ENABLE,
  output logic                  READY
);

  import dnc_pkg::*;

  //////////////////////////////////////////////////
  // Declarations
  //////////////////////////////////////////////////

  // Address stage
  logic   running;
  count_t j_idx, k_idx, i_idx;
  logic   j_last, k_last, i_last;

  // Tags for the data coming back next cycle
  logic   tag_valid;
  logic   tag_first;
  logic   tag_last;
  logic   tag_head;
  logic   tag_final;

  // MAC stage
  data_t  acc;
  data_t  acc_base;
  data_t  sum;
  logic   final_out;

  //////////////////////////////////////////////////
  // Address stage
  //////////////////////////////////////////////////

  assign j_last = (j_idx == count_t'(n_size - 1'b1));
  assign k_last = (k_idx == count_t'(w_size - 1'b1));
  assign i_last = (i_idx == count_t'(r_size - 1'b1));

  // M(j,k) at j*MAX_W+k, w(i,j) at i*MAX_N+j
  assign m_rd_addr = addr_t'(j_idx) * addr_t'(`DNC_MAX_W) + addr_t'(k_idx);
  assign w_rd_addr = addr_t'(i_idx) * addr_t'(`DNC_MAX_N) + addr_t'(j_idx);

  // j inner, k middle, i outer
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      running <= 1'b0;
      j_idx   <= '0;
      k_idx   <= '0;
      i_idx   <= '0;
    end else if (!running) begin
      if (load_done) begin
        running <= 1'b1;
        j_idx   <= '0;
        k_idx   <= '0;
        i_idx   <= '0;
      end
    end else if (!j_last) begin
      j_idx <= count_t'(j_idx + 1'b1);
    end else begin
      j_idx <= '0;
      if (!k_last) begin
        k_idx <= count_t'(k_idx + 1'b1);
      end else begin
        k_idx <= '0;
        if (!i_last) begin
          i_idx <= count_t'(i_idx + 1'b1);
        end else begin
          // Last read issued, pipeline drains on its own
          i_idx   <= '0;
          running <= 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Tag pipeline, matches the store read latency
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      tag_valid <= 1'b0;
      tag_first <= 1'b0;
      tag_last  <= 1'b0;
      tag_head  <= 1'b0;
      tag_final <= 1'b0;
    end else begin
      tag_valid <= running;
      tag_first <= (j_idx == '0);
      tag_last  <= j_last;
      tag_head  <= (k_idx == '0);
      tag_final <= j_last && k_last && i_last;
    end
  end

  //////////////////////////////////////////////////
  // Multiply-accumulate
  //////////////////////////////////////////////////

  // Fresh sum on row 0; wraps at the data width
  assign acc_base = tag_first ? '0 : acc;
  assign sum      = data_t'(acc_base + m_rd_data * w_rd_data);

  always_ff @(posedge CLK) begin
    if (tag_valid) begin
      acc <= sum;
    end
  end

  // Emit on the last row of each pair
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      R_OUT          <= '0;
      R_OUT_I_ENABLE <= 1'b0;
      R_OUT_K_ENABLE <= 1'b0;
      final_out      <= 1'b0;
      READY          <= 1'b0;
    end else begin
      R_OUT_K_ENABLE <= tag_valid && tag_last;
      R_OUT_I_ENABLE <= tag_valid && tag_last && tag_head;
      final_out      <= tag_valid && tag_last && tag_final;
      // One cycle behind the final strobe
      READY          <= final_out;
      if (tag_valid && tag_last) begin
        R_OUT <= sum;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/dnc_read_vectors.sv
/*
  DNC read vectors, r(i,k) = sum over j of M(j,k) * w(i,j).
  Loader fills a memory-word store and a weight store from the input streams,
  the accumulator then streams out r, k inner and i outer, and pulses READY.
  No back-pressure; START is honoured only when the block is idle.
*/

`default_nettype none

`include "dnc_config.svh"

module dnc_read_vectors (
  input  wire logic             CLK,
  input  wire logic             RST,

  // Control
  input  wire logic             START,
  output logic                  READY,

  input  wire logic             M_IN_J_ENABLE,
  input  wire logic             M_IN_K_ENABLE,
  input  wire logic             W_IN_I_ENABLE,
  input  wire logic             W_IN_J_ENABLE,
  output logic                  R_OUT_I_ENABLE,
  output logic                  R_OUT_K_ENABLE,

  // Data
  input  wire dnc_pkg::count_t  SIZE_R_IN,
  input  wire dnc_pkg::count_t  SIZE_N_IN,
  input  wire dnc_pkg::count_t  SIZE_W_IN,
  input  wire dnc_pkg::data_t   M_IN,
  input  wire dnc_pkg::weight_t W_IN,
  output dnc_pkg::data_t        R_OUT
);

  import dnc_pkg::*;

  //////////////////////////////////////////////////
  // Internal nets
  //////////////////////////////////////////////////

  // Loader to stores
  logic    m_wr_en, w_wr_en;
  addr_t   m_wr_addr, w_wr_addr;
  data_t   m_wr_data;
  weight_t w_wr_data;

  // Loader to accumulator
  logic    load_done;
  count_t  r_size, n_size, w_size;

  // Accumulator and stores
  addr_t   m_rd_addr, w_rd_addr;
  data_t   m_rd_data;
  weight_t w_rd_data;

  //////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////

  dnc_read_loader loader (
    .CLK(CLK), .RST(RST), .START(START),
    .SIZE_R_IN(SIZE_R_IN), .SIZE_N_IN(SIZE_N_IN), .SIZE_W_IN(SIZE_W_IN),
    .M_IN_J_ENABLE(M_IN_J_ENABLE), .M_IN_K_ENABLE(M_IN_K_ENABLE), .M_IN(M_IN),
    .W_IN_I_ENABLE(W_IN_I_ENABLE), .W_IN_J_ENABLE(W_IN_J_ENABLE), .W_IN(W_IN),
    .m_wr_en(m_wr_en), .m_wr_addr(m_wr_addr), .m_wr_data(m_wr_data),
    .w_wr_en(w_wr_en), .w_wr_addr(w_wr_addr), .w_wr_data(w_wr_data),
    .load_done(load_done), .r_size(r_size), .n_size(n_size), .w_size(w_size)
  );

  // M, N rows of MAX_W slots
  dnc_matrix_store #(.T(data_t), .DEPTH(`DNC_MAX_N * `DNC_MAX_W)) memory_store (
    .CLK(CLK),
    .wr_en(m_wr_en), .wr_addr(m_wr_addr), .wr_data(m_wr_data),
    .rd_addr(m_rd_addr), .rd_data(m_rd_data)
  );

  // w, R heads of MAX_N rows
  dnc_matrix_store #(.T(weight_t), .DEPTH(`DNC_MAX_R * `DNC_MAX_N)) weight_store (
    .CLK(CLK),
    .wr_en(w_wr_en), .wr_addr(w_wr_addr), .wr_data(w_wr_data),
    .rd_addr(w_rd_addr), .rd_data(w_rd_data)
  );

  dnc_read_accumulator accumulator (
    .CLK(CLK), .RST(RST), .load_done(load_done),
    .r_size(r_size), .n_size(n_size), .w_size(w_size),
    .m_rd_addr(m_rd_addr), .w_rd_addr(w_rd_addr),
    .m_rd_data(m_rd_data), .w_rd_data(w_rd_data),
    .R_OUT(R_OUT), .R_OUT_I_ENABLE(R_OUT_I_ENABLE),
    .R_OUT_K_ENABLE(R_OUT_K_ENABLE), .READY(READY)
  );

endmodule

`default_nettype wire

//--- testbench/dnc_read_vectors_tb.sv
/*
  Table-driven testbench for the DNC read-vector block.
  Each table row loads random or saturated M and w through the strobed streams,
  in one of three orders, and checks every r(i,k) against a reference sum.
  Also checks strobe ordering, the single READY pulse and quiet idle outputs.
*/

`default_nettype none

`include "dnc_config.svh"

module dnc_read_vectors_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import dnc_pkg::*;

  //////////////////////////////////////////////////
  // Test table
  //////////////////////////////////////////////////

  localparam int NUM_TESTS     = 7;
  localparam int ORDER_M_FIRST = 0;
  localparam int ORDER_W_FIRST = 1;
  localparam int ORDER_MIXED   = 2;
  localparam int FILL_RANDOM   = 0;
  localparam int FILL_MAX      = 1;
  // Reuse the previous row's operands
  localparam int FILL_KEEP     = 2;

  string test_name [NUM_TESTS] = '{"single_1x1x1", "max_4x8x8", "mixed_2x5x3_w_first",
    "mixed_3x2x7_mixed_gaps", "mixed_3x2x7_m_first", "mixed_3x2x7_w_first_gaps",
    "wrap_4x8x8_saturated"};
  int test_r     [NUM_TESTS] = '{1, 4, 2, 3, 3, 3, 4};
  int test_n     [NUM_TESTS] = '{1, 8, 5, 2, 2, 2, 8};
  int test_w     [NUM_TESTS] = '{1, 8, 3, 7, 7, 7, 8};
  int test_order [NUM_TESTS] = '{ORDER_M_FIRST, ORDER_MIXED, ORDER_W_FIRST, ORDER_MIXED,
    ORDER_M_FIRST, ORDER_W_FIRST, ORDER_MIXED};
  bit test_gaps  [NUM_TESTS] = '{0, 0, 1, 1, 0, 1, 1};
  int test_fill  [NUM_TESTS] = '{FILL_RANDOM, FILL_RANDOM, FILL_RANDOM, FILL_RANDOM,
    FILL_KEEP, FILL_KEEP, FILL_MAX};

  //////////////////////////////////////////////////
  // DUT and clock
  //////////////////////////////////////////////////

  logic    CLK, RST, START, READY;
  logic    M_IN_J_ENABLE, M_IN_K_ENABLE, W_IN_I_ENABLE, W_IN_J_ENABLE;
  logic    R_OUT_I_ENABLE, R_OUT_K_ENABLE;
  count_t  SIZE_R_IN, SIZE_N_IN, SIZE_W_IN;
  data_t   M_IN, R_OUT;
  weight_t W_IN;

  dnc_read_vectors i_dnc_read_vectors (
    .CLK(CLK), .RST(RST), .START(START), .READY(READY),
    .M_IN_J_ENABLE(M_IN_J_ENABLE), .M_IN_K_ENABLE(M_IN_K_ENABLE),
    .W_IN_I_ENABLE(W_IN_I_ENABLE), .W_IN_J_ENABLE(W_IN_J_ENABLE),
    .R_OUT_I_ENABLE(R_OUT_I_ENABLE), .R_OUT_K_ENABLE(R_OUT_K_ENABLE),
    .SIZE_R_IN(SIZE_R_IN), .SIZE_N_IN(SIZE_N_IN), .SIZE_W_IN(SIZE_W_IN),
    .M_IN(M_IN), .W_IN(W_IN), .R_OUT(R_OUT)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // Reference model state and run control
  //////////////////////////////////////////////////

  data_t   mem_m    [`DNC_MAX_N][`DNC_MAX_W];
  weight_t mem_w    [`DNC_MAX_R][`DNC_MAX_N];
  data_t   expect_r [`DNC_MAX_R * `DNC_MAX_W];
  string   current_test = "reset";
  int      error_count  = 0;
  int      cycle_count  = 0;
  int      cycle_limit  = 100;

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      error_count = error_count + 1;
      stop_with_failure($sformatf("mismatch: test %s, %s: expected %0h, actual %0h",
                                  current_test, what, expected, actual));
    end
  endtask

  // Hard stop once the run outlasts every row's budget
  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      stop_with_failure($sformatf("Timeout after %0d cycles in test %s, READY never came",
                                  cycle_count, current_test));
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // No output activity outside an operation
  task automatic check_quiet();
    check_value("READY while idle", 32'd0, 32'(READY));
    check_value("R_OUT_K_ENABLE while idle", 32'd0, 32'(R_OUT_K_ENABLE));
    check_value("R_OUT_I_ENABLE while idle", 32'd0, 32'(R_OUT_I_ENABLE));
  endtask

  task automatic drive_inputs(input logic m_j, input logic m_k, input data_t m_data,
                              input logic w_i, input logic w_j, input weight_t w_data);
    M_IN_J_ENABLE = m_j;
    M_IN_K_ENABLE = m_k;
    M_IN          = m_data;
    W_IN_I_ENABLE = w_i;
    W_IN_J_ENABLE = w_j;
    W_IN          = w_data;
  endtask

  // New operands, then r(i,k) = sum over j of M(j,k)*w(i,j), mod 2^16
  task automatic prepare_operands(input int t);
    logic [31:0] acc;
    for (int j = 0; j < `DNC_MAX_N; j++) begin
      for (int k = 0; k < `DNC_MAX_W; k++) begin
        if (test_fill[t] == FILL_RANDOM) mem_m[j][k] = data_t'($urandom);
        else if (test_fill[t] == FILL_MAX) mem_m[j][k] = '1;
      end
      for (int i = 0; i < `DNC_MAX_R; i++) begin
        if (test_fill[t] == FILL_RANDOM) mem_w[i][j] = weight_t'($urandom);
        else if (test_fill[t] == FILL_MAX) mem_w[i][j] = '1;
      end
    end
    for (int i = 0; i < test_r[t]; i++) begin
      for (int k = 0; k < test_w[t]; k++) begin
        acc = '0;
        for (int j = 0; j < test_n[t]; j++) begin
          acc = acc + 32'(mem_m[j][k]) * 32'(mem_w[i][j]);
        end
        expect_r[i * test_w[t] + k] = acc[`DNC_DATA_SIZE-1:0];
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Stream drivers and result collection
  //////////////////////////////////////////////////

  task automatic drive_streams(input int t);
    int mi, wi, m_total, w_total;
    bit send_m, send_w;
    mi = 0;
    wi = 0;
    m_total = test_n[t] * test_w[t];
    w_total = test_r[t] * test_n[t];
    while (mi < m_total || wi < w_total) begin
      send_m = 1'b0;
      send_w = 1'b0;
      // Optional idle cycle, one in three
      if (!(test_gaps[t] && $urandom_range(2) == 0)) begin
        if (test_order[t] == ORDER_M_FIRST) begin
          send_m = (mi < m_total);
          send_w = !send_m;
        end else if (test_order[t] == ORDER_W_FIRST) begin
          send_w = (wi < w_total);
          send_m = !send_w;
        end else begin
          send_m = (mi < m_total) && ($urandom_range(1) == 1);
          send_w = (wi < w_total) && ($urandom_range(1) == 1);
        end
      end
      @(negedge CLK);
      check_quiet();
      // Row start strobe rides on the first element; noise on idle data
      drive_inputs(send_m && (mi % test_w[t] == 0), send_m,
                   send_m ? mem_m[mi / test_w[t]][mi % test_w[t]] : data_t'($urandom),
                   send_w && (wi % test_n[t] == 0), send_w,
                   send_w ? mem_w[wi / test_n[t]][wi % test_n[t]] : weight_t'($urandom));
      if (send_m) mi++;
      if (send_w) wi++;
    end
    @(negedge CLK);
    check_quiet();
    drive_inputs(1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
  endtask

  // Results in k-inner, i-outer order, then READY right after the last one
  task automatic collect_results(input int t);
    int  idx, total;
    bit  prev_k, done;
    idx    = 0;
    total  = test_r[t] * test_w[t];
    prev_k = 1'b0;
    done   = 1'b0;
    while (!done) begin
      @(negedge CLK);
      if (READY) begin
        check_value("result count at READY", 32'(total), 32'(idx));
        check_value("final strobe before READY", 32'd1, 32'(prev_k));
        done = 1'b1;
      end
      if (R_OUT_K_ENABLE) begin
        check_value("extra result before READY", 32'd1, 32'(idx < total));
        check_value($sformatf("r(%0d,%0d)", idx / test_w[t], idx % test_w[t]),
                    32'(expect_r[idx]), 32'(R_OUT));
        check_value("R_OUT_I_ENABLE", 32'(idx % test_w[t] == 0), 32'(R_OUT_I_ENABLE));
        idx++;
      end else begin
        check_value("R_OUT_I_ENABLE without K strobe", 32'd0, 32'(R_OUT_I_ENABLE));
      end
      prev_k = R_OUT_K_ENABLE;
      // Loader is idle while the stores are read, stray strobes must not land
      drive_inputs(1'($urandom_range(1)), 1'($urandom_range(1)), data_t'($urandom),
                   1'($urandom_range(1)), 1'($urandom_range(1)), weight_t'($urandom));
    end
  endtask

  task automatic run_test(input int t);
    current_test = test_name[t];
    prepare_operands(t);
    // Strobes before START must be ignored
    repeat (3) begin
      @(negedge CLK);
      check_quiet();
      drive_inputs(1'($urandom_range(1)), 1'($urandom_range(1)), data_t'($urandom),
                   1'($urandom_range(1)), 1'($urandom_range(1)), weight_t'($urandom));
    end
    @(negedge CLK);
    check_quiet();
    drive_inputs(1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
    START     = 1'b1;
    SIZE_R_IN = count_t'(test_r[t]);
    SIZE_N_IN = count_t'(test_n[t]);
    SIZE_W_IN = count_t'(test_w[t]);
    @(negedge CLK);
    check_quiet();
    // Sizes must have been latched
    START     = 1'b0;
    SIZE_R_IN = '0;
    SIZE_N_IN = '0;
    SIZE_W_IN = '0;
    drive_streams(t);
    collect_results(t);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'he8c7_f401));
    for (int t = 0; t < NUM_TESTS; t++) begin
      cycle_limit = cycle_limit
        + (test_n[t] * test_w[t] + test_r[t] * test_n[t] + 8) * 4
        + test_r[t] * test_w[t] * (test_n[t] + 4);
    end
    RST       = 1'b1;
    START     = 1'b0;
    SIZE_R_IN = '0;
    SIZE_N_IN = '0;
    SIZE_W_IN = '0;
    drive_inputs(1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
    repeat (4) @(negedge CLK);
    RST = 1'b0;
    check_value("R_OUT after reset", 32'd0, 32'(R_OUT));
    check_quiet();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    // READY only once, nothing trailing
    current_test = "final idle";
    repeat (4) begin
      @(negedge CLK);
      check_quiet();
    end
    if (error_count == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      stop_with_failure("Errors were recorded during the run");
    end
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+hw
hw/dnc_pkg.sv
hw/dnc_matrix_store.sv
hw/dnc_read_loader.sv
hw/dnc_read_accumulator.sv
hw/dnc_read_vectors.sv
testbench/dnc_read_vectors_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the DNC read-vector testbench with Verilator.
# Exit status is nonzero when the build fails or the run reports failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f build.f --top-module dnc_read_vectors_tb -o sim_dnc
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_dnc > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

exit 0
